// File: design/soc_pkg.sv
package soc_pkg;

    // ~~~~~~~~~~~~~~~~~~~~
    // bus vector types.
    // ~~~~~~~~~~~~~~~~~~~~
    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0]  mask_t;
    typedef logic [63:0] cycle_t;

    // ~~~~~~~~~~~~~~~~~~~~
    // address map.
    // ~~~~~~~~~~~~~~~~~~~~
    // ram is the whole region with the upper half zero.
    localparam addr_t ram_base   = 32'h0000_0000;
    // one word of leds.
    localparam addr_t leds_base  = 32'h0001_0000;
    // count lo, count hi, compare lo, compare hi.
    localparam addr_t timer_base = 32'h0003_0000;

    // ~~~~~~~~~~~~~~~~~~~~
    // arbiter states.
    // ~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [1:0] {
        arb_idle,
        arb_instr,
        arb_data
    } arb_state_t;

endpackage

// File: design/bus_arbiter.sv
`timescale 1ns/100ps

module bus_arbiter (
    input  logic           pll_clk,
    input  logic           rst_n,

    input  soc_pkg::addr_t instr_address,
    input  logic           instr_read,
    output soc_pkg::word_t instr_read_value,
    output logic           instr_ready,

    input  soc_pkg::addr_t data_address,
    input  logic           data_read,
    input  logic           data_write,
    input  soc_pkg::mask_t data_write_mask,
    input  soc_pkg::word_t data_write_value,
    output soc_pkg::word_t data_read_value,
    output logic           data_ready,

    output soc_pkg::addr_t mem_address,
    output logic           mem_read,
    output logic           mem_write,
    output soc_pkg::mask_t mem_write_mask,
    output soc_pkg::word_t mem_write_value,
    input  soc_pkg::word_t mem_read_value,
    input  logic           mem_ready
);

    soc_pkg::arb_state_t state;
    soc_pkg::arb_state_t state_next;
    logic                last_data;
    logic                instr_req;
    logic                data_req;

    assign instr_req = instr_read;
    assign data_req  = data_read | data_write;

    // data first, unless it had the last grant.
    always_comb begin
        state_next = state;
        case (state)
            soc_pkg::arb_idle: begin
                if (data_req && (!instr_req || !last_data)) begin
                    state_next = soc_pkg::arb_data;
                end else if (instr_req) begin
                    state_next = soc_pkg::arb_instr;
                end
            end
            soc_pkg::arb_instr,
            soc_pkg::arb_data: begin
                if (mem_ready) begin
                    state_next = soc_pkg::arb_idle;
                end
            end
            default: state_next = soc_pkg::arb_idle;
        endcase
    end

    always_ff @(posedge pll_clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= soc_pkg::arb_idle;
            last_data <= 1'b0;
        end else begin
            state <= state_next;
            if (state_next == soc_pkg::arb_data) begin
                last_data <= 1'b1;
            end else if (state_next == soc_pkg::arb_instr) begin
                last_data <= 1'b0;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // common bus mux.
    // ~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        mem_address     = '0;
        mem_read        = 1'b0;
        mem_write       = 1'b0;
        mem_write_mask  = '0;
        mem_write_value = '0;
        case (state)
            soc_pkg::arb_instr: begin
                mem_address = instr_address;
                mem_read    = instr_read;
            end
            soc_pkg::arb_data: begin
                mem_address     = data_address;
                mem_read        = data_read;
                mem_write       = data_write;
                mem_write_mask  = data_write_mask;
                mem_write_value = data_write_value;
            end
            default: ;
        endcase
    end

    // response goes back to the owner only.
    assign instr_ready      = (state == soc_pkg::arb_instr) && mem_ready;
    assign data_ready       = (state == soc_pkg::arb_data) && mem_ready;
    assign instr_read_value = (state == soc_pkg::arb_instr) ? mem_read_value : '0;
    assign data_read_value  = (state == soc_pkg::arb_data) ? mem_read_value : '0;

    a_one_ready: assert property (@(posedge pll_clk) disable iff (!rst_n)
        !(instr_ready && data_ready));

    a_no_rw: assert property (@(posedge pll_clk) disable iff (!rst_n)
        !(mem_read && mem_write));

endmodule

// File: design/mem_decoder.sv
`timescale 1ns/100ps

module mem_decoder (
    input  logic           pll_clk,
    input  logic           rst_n,

    input  soc_pkg::addr_t mem_address,
    input  logic           mem_read,
    input  logic           mem_write,
    input  soc_pkg::mask_t mem_write_mask,
    input  soc_pkg::word_t mem_write_value,
    output soc_pkg::word_t mem_read_value,
    output logic           mem_ready,

    output logic           ram_sel,
    output logic           timer_sel,
    input  soc_pkg::word_t ram_read_value,
    input  logic           ram_ready,
    input  soc_pkg::word_t timer_read_value,
    input  logic           timer_ready,

    output logic [7:0]     leds
);

    logic access;
    logic ram_hit;
    logic leds_hit;
    logic timer_hit;
    logic leds_sel;
    logic unmapped_sel;

    assign access = mem_read | mem_write;

    // ~~~~~~~~~~~~~~~~~~~~
    // region decode.
    // ~~~~~~~~~~~~~~~~~~~~
    assign ram_hit   = mem_address[31:16] == soc_pkg::ram_base[31:16];
    assign leds_hit  = mem_address[31:2] == soc_pkg::leds_base[31:2];
    assign timer_hit = mem_address[31:4] == soc_pkg::timer_base[31:4];

    assign ram_sel      = access && ram_hit;
    assign leds_sel     = access && leds_hit;
    assign timer_sel    = access && timer_hit;
    assign unmapped_sel = access && !ram_hit && !leds_hit && !timer_hit;

    // only lane 0 reaches the leds.
    always_ff @(posedge pll_clk or negedge rst_n) begin
        if (!rst_n) begin
            leds <= 8'h00;
        end else if (leds_sel && mem_write && mem_write_mask[0]) begin
            leds <= mem_write_value[7:0];
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // response merge.
    // ~~~~~~~~~~~~~~~~~~~~
    // unmapped reads give zero and finish at once.
    assign mem_read_value = (ram_sel ? ram_read_value : 32'h0)
                          | (timer_sel ? timer_read_value : 32'h0)
                          | (leds_sel ? {24'h0, leds} : 32'h0);

    assign mem_ready = (ram_sel & ram_ready)
                     | (timer_sel & timer_ready)
                     | leds_sel
                     | unmapped_sel;

    a_one_sel: assert property (@(posedge pll_clk) disable iff (!rst_n)
        $onehot0({ram_sel, leds_sel, timer_sel, unmapped_sel}));

endmodule

// File: design/ram.sv
`timescale 1ns/100ps

module ram #(
    parameter int RAM_WORDS = 1024
) (
    input  logic           pll_clk,

    input  logic           sel,
    input  soc_pkg::addr_t address,
    input  soc_pkg::mask_t write_mask,
    input  soc_pkg::word_t write_value,
    output soc_pkg::word_t read_value,
    output logic           ready
);

    // RAM_WORDS is a power of two, so the slice wraps the index.
    localparam int IDX_W = $clog2(RAM_WORDS);

    soc_pkg::word_t   mem [RAM_WORDS];
    logic [IDX_W-1:0] word_index;
    logic             start;

    assign word_index = address[IDX_W+1:2];

    // one access per select and ready drops after a cycle.
    assign start = sel && !ready;

    always_ff @(posedge pll_clk) begin
        ready <= start;
        if (start) begin
            read_value <= mem[word_index];
            for (int i = 0; i < 4; i++) begin
                if (write_mask[i]) begin
                    mem[word_index][8*i +: 8] <= write_value[8*i +: 8];
                end
            end
        end
    end

    a_ready_after_sel: assert property (@(posedge pll_clk)
        $rose(ready) |-> $past(sel));

endmodule

// File: design/cycle_timer.sv
`timescale 1ns/100ps

module cycle_timer (
    input  logic           pll_clk,
    input  logic           rst_n,

    input  logic           sel,
    input  soc_pkg::addr_t address,
    input  soc_pkg::mask_t write_mask,
    input  soc_pkg::word_t write_value,
    output soc_pkg::word_t read_value,
    output logic           ready,

    output logic           timer_irq
);

    soc_pkg::cycle_t count;
    soc_pkg::cycle_t compare;
    logic            write_lo;
    logic            write_hi;

    // a write carries a nonzero mask.
    assign write_lo = sel && (|write_mask) && (address[3:2] == 2'd2);
    assign write_hi = sel && (|write_mask) && (address[3:2] == 2'd3);

    always_ff @(posedge pll_clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else begin
            count <= count + 64'd1;
        end
    end

    // compare halves, byte by byte.
    always_ff @(posedge pll_clk or negedge rst_n) begin
        if (!rst_n) begin
            compare <= '1;
        end else begin
            for (int i = 0; i < 4; i++) begin
                if (write_lo && write_mask[i]) begin
                    compare[8*i +: 8] <= write_value[8*i +: 8];
                end
                if (write_hi && write_mask[i]) begin
                    compare[32 + 8*i +: 8] <= write_value[8*i +: 8];
                end
            end
        end
    end

    always_comb begin
        case (address[3:2])
            2'd0:    read_value = count[31:0];
            2'd1:    read_value = count[63:32];
            2'd2:    read_value = compare[31:0];
            default: read_value = compare[63:32];
        endcase
    end

    assign ready     = sel;
    assign timer_irq = count >= compare;

endmodule

// File: design/soc_bus.sv
`timescale 1ns/100ps

module soc_bus #(
    parameter int RAM_WORDS = 1024
) (
    input  logic           pll_clk,
    input  logic           rst_n,

    input  soc_pkg::addr_t instr_address,
    input  logic           instr_read,
    output soc_pkg::word_t instr_read_value,
    output logic           instr_ready,

    input  soc_pkg::addr_t data_address,
    input  logic           data_read,
    input  logic           data_write,
    input  soc_pkg::mask_t data_write_mask,
    input  soc_pkg::word_t data_write_value,
    output soc_pkg::word_t data_read_value,
    output logic           data_ready,

    output logic [7:0]     leds,
    output logic           timer_irq
);

    // common bus.
    soc_pkg::addr_t mem_address;
    logic           mem_read;
    logic           mem_write;
    soc_pkg::mask_t mem_write_mask;
    soc_pkg::word_t mem_write_value;
    soc_pkg::word_t mem_read_value;
    logic           mem_ready;

    // target side.
    logic           ram_sel;
    soc_pkg::word_t ram_read_value;
    logic           ram_ready;
    logic           timer_sel;
    soc_pkg::word_t timer_read_value;
    logic           timer_ready;

    bus_arbiter u_bus_arbiter (
        .pll_clk          (pll_clk),
        .rst_n            (rst_n),
        .instr_address    (instr_address),
        .instr_read       (instr_read),
        .instr_read_value (instr_read_value),
        .instr_ready      (instr_ready),
        .data_address     (data_address),
        .data_read        (data_read),
        .data_write       (data_write),
        .data_write_mask  (data_write_mask),
        .data_write_value (data_write_value),
        .data_read_value  (data_read_value),
        .data_ready       (data_ready),
        .mem_address      (mem_address),
        .mem_read         (mem_read),
        .mem_write        (mem_write),
        .mem_write_mask   (mem_write_mask),
        .mem_write_value  (mem_write_value),
        .mem_read_value   (mem_read_value),
        .mem_ready        (mem_ready)
    );

    mem_decoder u_mem_decoder (
        .pll_clk          (pll_clk),
        .rst_n            (rst_n),
        .mem_address      (mem_address),
        .mem_read         (mem_read),
        .mem_write        (mem_write),
        .mem_write_mask   (mem_write_mask),
        .mem_write_value  (mem_write_value),
        .mem_read_value   (mem_read_value),
        .mem_ready        (mem_ready),
        .ram_sel          (ram_sel),
        .timer_sel        (timer_sel),
        .ram_read_value   (ram_read_value),
        .ram_ready        (ram_ready),
        .timer_read_value (timer_read_value),
        .timer_ready      (timer_ready),
        .leds             (leds)
    );

    ram #(
        .RAM_WORDS (RAM_WORDS)
    ) u_ram (
        .pll_clk     (pll_clk),
        .sel         (ram_sel),
        .address     (mem_address),
        .write_mask  (mem_write_mask),
        .write_value (mem_write_value),
        .read_value  (ram_read_value),
        .ready       (ram_ready)
    );

    cycle_timer u_cycle_timer (
        .pll_clk     (pll_clk),
        .rst_n       (rst_n),
        .sel         (timer_sel),
        .address     (mem_address),
        .write_mask  (mem_write_mask),
        .write_value (mem_write_value),
        .read_value  (timer_read_value),
        .ready       (timer_ready),
        .timer_irq   (timer_irq)
    );

endmodule

// File: verification/soc_bus_checker.sv
`timescale 1ns/100ps

module soc_bus_checker (
    input  logic           pll_clk,
    input  logic           rst_n,

    input  logic           instr_read,
    input  soc_pkg::word_t instr_read_value,
    input  logic           instr_ready,
    input  logic           data_read,
    input  soc_pkg::word_t data_read_value,
    input  logic           data_ready,
    input  logic [7:0]     leds,
    input  logic           timer_irq,

    // posted by the testbench for the current entry.
    input  logic [95:0]    test_name,
    input  logic [3:0]     check_mask,
    input  soc_pkg::word_t expected,

    output int             errors
);

    soc_pkg::word_t last_read;

    task automatic compare_word(input string what, input soc_pkg::word_t exp_value,
                                input soc_pkg::word_t act_value);
        if (act_value !== exp_value) begin
            errors = errors + 1;
            $display("Mismatch %s %s: expected %h, actual %h",
                     string'(test_name), what, exp_value, act_value);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // one completed read.
    // ~~~~~~~~~~~~~~~~~~~~
    task automatic check_read(input soc_pkg::word_t actual);
        if (check_mask[0]) begin
            compare_word("read value", expected, actual);
        end
        if (check_mask[1]) begin
            compare_word("leds", expected, {24'h0, leds});
        end
        if (check_mask[2]) begin
            compare_word("timer_irq", expected, {31'h0, timer_irq});
        end
        if (check_mask[3] && actual <= last_read) begin
            errors = errors + 1;
            $display("count low did not increase in %s: previous %h, now %h",
                     string'(test_name), last_read, actual);
        end
        last_read = actual;
    endtask

    // sampled on the rising edge, where the ready cycle ends.
    always @(posedge pll_clk) begin
        if (!rst_n) begin
            errors    = 0;
            last_read = '0;
        end else begin
            if (instr_ready && data_ready) begin
                errors = errors + 1;
                $display("instr_ready and data_ready were high together in %s",
                         string'(test_name));
            end
            if (instr_ready && instr_read) begin
                check_read(instr_read_value);
            end
            if (data_ready && data_read) begin
                check_read(data_read_value);
            end
        end
    end

endmodule

// File: verification/soc_bus_tb.sv
`timescale 1ns/100ps

module soc_bus_tb;

    localparam int RAM_WORDS = 256;
    localparam int TIMEOUT   = 50;

    localparam logic [1:0] port_instr = 2'd0;
    localparam logic [1:0] port_data  = 2'd1;
    localparam logic [1:0] port_both  = 2'd2;

    // checker mask bits are value, leds, irq and increasing count.
    localparam logic [3:0] chk_none  = 4'b0000;
    localparam logic [3:0] chk_value = 4'b0001;
    localparam logic [3:0] chk_leds  = 4'b0011;
    localparam logic [3:0] chk_irq   = 4'b0100;
    localparam logic [3:0] chk_inc   = 4'b1000;

    typedef struct packed {
        logic [95:0]    name;
        logic [1:0]     port;
        logic           write;
        soc_pkg::addr_t address;
        soc_pkg::mask_t mask;
        soc_pkg::word_t value;
        soc_pkg::word_t expected;
        logic [3:0]     checks;
    } entry_t;

    logic           pll_clk;
    logic           rst_n;
    soc_pkg::addr_t instr_address;
    logic           instr_read;
    soc_pkg::word_t instr_read_value;
    logic           instr_ready;
    soc_pkg::addr_t data_address;
    logic           data_read;
    logic           data_write;
    soc_pkg::mask_t data_write_mask;
    soc_pkg::word_t data_write_value;
    soc_pkg::word_t data_read_value;
    logic           data_ready;
    logic [7:0]     leds;
    logic           timer_irq;

    logic [95:0]    test_name;
    logic [3:0]     check_mask;
    soc_pkg::word_t expected;
    int             mismatches;
    int             timeouts;
    int             seed;
    entry_t         table_q[$];
    soc_pkg::word_t shadow [RAM_WORDS];

    soc_bus #(
        .RAM_WORDS (RAM_WORDS)
    ) u_soc_bus (
        .pll_clk          (pll_clk),
        .rst_n            (rst_n),
        .instr_address    (instr_address),
        .instr_read       (instr_read),
        .instr_read_value (instr_read_value),
        .instr_ready      (instr_ready),
        .data_address     (data_address),
        .data_read        (data_read),
        .data_write       (data_write),
        .data_write_mask  (data_write_mask),
        .data_write_value (data_write_value),
        .data_read_value  (data_read_value),
        .data_ready       (data_ready),
        .leds             (leds),
        .timer_irq        (timer_irq)
    );

    soc_bus_checker u_checker (
        .pll_clk          (pll_clk),
        .rst_n            (rst_n),
        .instr_read       (instr_read),
        .instr_read_value (instr_read_value),
        .instr_ready      (instr_ready),
        .data_read        (data_read),
        .data_read_value  (data_read_value),
        .data_ready       (data_ready),
        .leds             (leds),
        .timer_irq        (timer_irq),
        .test_name        (test_name),
        .check_mask       (check_mask),
        .expected         (expected),
        .errors           (mismatches)
    );

    always #2 pll_clk = ~pll_clk;

    task automatic idle_inputs();
        instr_address    = '0;
        instr_read       = 1'b0;
        data_address     = '0;
        data_read        = 1'b0;
        data_write       = 1'b0;
        data_write_mask  = '0;
        data_write_value = '0;
    endtask

    task automatic add_entry(input logic [95:0] name, input logic [1:0] port,
                             input logic write, input soc_pkg::addr_t address,
                             input soc_pkg::mask_t mask, input soc_pkg::word_t value,
                             input soc_pkg::word_t exp_value, input logic [3:0] checks);
        table_q.push_back({name, port, write, address, mask, value, exp_value, checks});
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // ram model.
    // ~~~~~~~~~~~~~~~~~~~~
    // the word index wraps modulo RAM_WORDS.
    task automatic ram_write(input logic [95:0] name, input soc_pkg::addr_t address,
                             input soc_pkg::mask_t mask, input soc_pkg::word_t value);
        int idx;
        idx = (address >> 2) % RAM_WORDS;
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) begin
                shadow[idx][8*b +: 8] = value[8*b +: 8];
            end
        end
        add_entry(name, port_data, 1'b1, address, mask, value, '0, chk_none);
    endtask

    task automatic ram_read(input logic [95:0] name, input logic [1:0] port,
                            input soc_pkg::addr_t address);
        int idx;
        idx = (address >> 2) % RAM_WORDS;
        add_entry(name, port, 1'b0, address, '0, '0, shadow[idx], chk_value);
    endtask

    task automatic build_table();
        for (int i = 0; i < 8; i++) begin
            ram_write("fill", 4 * i, 4'hf, $random(seed));
        end
        ram_write("part_lo", 32'h4, 4'b0101, $random(seed));
        ram_write("part_hi", 32'h8, 4'b1000, $random(seed));
        ram_write("part_mid", 32'hc, 4'b0110, $random(seed));
        for (int i = 0; i < 8; i++) begin
            ram_read("data_rd", port_data, 4 * i);
        end
        ram_read("instr_rd", port_instr, 32'h10);
        ram_read("instr_wrap", port_instr, RAM_WORDS * 4 + 4);
        ram_read("instr_wrap2", port_instr, RAM_WORDS * 8 + 28);
        ram_read("both_rd", port_both, 32'h8);
        ram_read("both_rd2", port_both, 32'h14);

        add_entry("led_wr", port_data, 1'b1, soc_pkg::leds_base, 4'h1, 32'hdead_bea5,
                  '0, chk_none);
        add_entry("led_rd", port_data, 1'b0, soc_pkg::leds_base, '0, '0, 32'ha5, chk_leds);
        // lane 0 left out, so the leds keep their value.
        add_entry("led_keep", port_data, 1'b1, soc_pkg::leds_base, 4'b1110, 32'h1234_5678,
                  '0, chk_none);
        add_entry("led_rd2", port_data, 1'b0, soc_pkg::leds_base, '0, '0, 32'ha5, chk_leds);

        add_entry("cnt_rd1", port_data, 1'b0, soc_pkg::timer_base, '0, '0, '0, chk_none);
        add_entry("cnt_rd2", port_data, 1'b0, soc_pkg::timer_base, '0, '0, '0, chk_inc);
        add_entry("cmp_hi0", port_data, 1'b1, soc_pkg::timer_base + 12, 4'hf, '0, '0, chk_none);
        add_entry("cmp_lo0", port_data, 1'b1, soc_pkg::timer_base + 8, 4'hf, '0, '0, chk_none);
        add_entry("irq_on", port_data, 1'b0, soc_pkg::timer_base + 8, '0, '0, 32'h1, chk_irq);
        add_entry("cmp_lo1", port_data, 1'b1, soc_pkg::timer_base + 8, 4'hf, '1, '0, chk_none);
        add_entry("cmp_hi1", port_data, 1'b1, soc_pkg::timer_base + 12, 4'hf, '1, '0, chk_none);
        add_entry("irq_off", port_data, 1'b0, soc_pkg::timer_base + 8, '0, '0, '0, chk_irq);

        add_entry("unmapped", port_data, 1'b0, 32'h0002_0000, '0, '0, '0, chk_value);
        add_entry("unmapped_i", port_instr, 1'b0, 32'h8000_0000, '0, '0, '0, chk_value);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // one table entry.
    // ~~~~~~~~~~~~~~~~~~~~
    task automatic run_entry(input entry_t e);
        logic instr_done;
        logic data_done;
        int   waited;
        @(negedge pll_clk);
        test_name        = e.name;
        check_mask       = e.checks;
        expected         = e.expected;
        instr_address    = e.address;
        instr_read       = e.port != port_data;
        data_address     = e.address;
        data_read        = (e.port != port_instr) && !e.write;
        data_write       = (e.port == port_data) && e.write;
        data_write_mask  = e.mask;
        data_write_value = e.value;
        instr_done       = !instr_read;
        data_done        = !(data_read || data_write);
        waited           = 0;
        while (!(instr_done && data_done) && waited < TIMEOUT) begin
            @(negedge pll_clk);
            waited = waited + 1;
            // a port that saw ready one cycle ago lets go.
            if (instr_done) begin
                instr_read = 1'b0;
            end
            if (data_done) begin
                data_read  = 1'b0;
                data_write = 1'b0;
            end
            if (instr_ready) begin
                instr_done = 1'b1;
            end
            if (data_ready) begin
                data_done = 1'b1;
            end
        end
        if (!(instr_done && data_done)) begin
            timeouts = timeouts + 1;
            $display("timeout: no ready within %0d cycles in %s", TIMEOUT, string'(e.name));
        end
    endtask

    initial begin
        pll_clk    = 1'b0;
        rst_n      = 1'b0;
        seed       = 32'h3905;
        timeouts   = 0;
        test_name  = '0;
        check_mask = chk_none;
        expected   = '0;
        idle_inputs();
        build_table();
        repeat (16) @(negedge pll_clk);
        rst_n = 1'b1;

        foreach (table_q[i]) begin
            run_entry(table_q[i]);
        end
        @(negedge pll_clk);
        idle_inputs();
        @(negedge pll_clk);

        $display("errors: %0d from checks, %0d timeouts", mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: soc_bus.f
design/soc_pkg.sv
design/bus_arbiter.sv
design/mem_decoder.sv
design/ram.sv
design/cycle_timer.sv
design/soc_bus.sv
verification/soc_bus_checker.sv
verification/soc_bus_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= soc_bus_tb
FILELIST  ?= soc_bus.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -Wno-fatal
FAIL_MSG  ?= SOME TESTS FAILED
PASS_MSG  ?= ALL TESTS PASSED

SIM     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM)
	$(SIM) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
